/* dv/mipsTb.sv */
`timescale 1ns/1ns
`include "mipsConsts.svh"

module mipsTb;

    localparam int MemWords  = 256;
    localparam int WaitLimit = 2000;
    localparam int TailLimit = 8;

    logic                  CLK = 1'b0;
    logic                  arstN;
    logic [`MIPS_XLEN-1:0] instrAddr;
    logic [`MIPS_XLEN-1:0] instrData;
    logic [`MIPS_XLEN-1:0] dataAddr;
    logic                  memRead;
    logic                  memWrite;
    logic [`MIPS_XLEN-1:0] dataWrite;
    logic [`MIPS_XLEN-1:0] dataRead;
    logic                  sys;

    logic [31:0] imem [MemWords];
    logic [31:0] dmem [MemWords];
    logic [31:0] regModel [`MIPS_NUM_REGS];
    // Expected stores in program order
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    logic [31:0] lfsr;
    logic [31:0] nextStoreAddr;
    int          pcIdx;
    int          errors;
    int          storesSeen;
    logic        sysSeen;

    mipsCore i_dut (
        .CLK       (CLK),
        .arstN     (arstN),
        .instrAddr (instrAddr),
        .instrData (instrData),
        .dataAddr  (dataAddr),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .dataWrite (dataWrite),
        .dataRead  (dataRead),
        .sys       (sys)
    );

    always #50 CLK = ~CLK;

    // Both memories answer in the same cycle
    assign instrData = imem[instrAddr[9:2]];
    assign dataRead  = dmem[dataAddr[9:2]];

    always @(posedge CLK) begin
        if (memWrite) begin
            dmem[dataAddr[9:2]] <= dataWrite;
        end
    end

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Reference results for the R-type ALU ops
    function automatic logic [31:0] refR(input logic [5:0] fn, input logic [31:0] a,
                                         input logic [31:0] b, input logic [4:0] sh);
        case (fn)
            `MIPS_FN_ADDU: return a + b;
            `MIPS_FN_SUBU: return a - b;
            `MIPS_FN_AND:  return a & b;
            `MIPS_FN_OR:   return a | b;
            `MIPS_FN_XOR:  return a ^ b;
            `MIPS_FN_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `MIPS_FN_SLL:  return b << sh;
            `MIPS_FN_SRL:  return b >> sh;
            default:       return 32'd0;
        endcase
    endfunction

    task automatic emitWord(input logic [31:0] w);
        imem[pcIdx] = w;
        pcIdx++;
    endtask

    task automatic emitR(input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd,
                         input logic [4:0] sh, input logic [5:0] fn);
        emitWord({`MIPS_OP_RTYPE, rs, rt, rd, sh, fn});
    endtask

    task automatic emitI(input logic [5:0] op, input logic [4:0] rs, input logic [4:0] rt,
                         input logic [15:0] imm);
        emitWord({op, rs, rt, imm});
    endtask

    task automatic aluR(input logic [5:0] fn, input logic [4:0] rd, input logic [4:0] rs,
                        input logic [4:0] rt, input logic [4:0] sh);
        emitR(rs, rt, rd, sh, fn);
        regModel[rd] = refR(fn, regModel[rs], regModel[rt], sh);
    endtask

    // LUI then a dependent ORI on the same register
    task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
        emitI(`MIPS_OP_LUI, 5'd0, rd, value[31:16]);
        emitI(`MIPS_OP_ORI, rd, rd, value[15:0]);
        regModel[rd] = value;
    endtask

    task automatic storeReg(input logic [4:0] rt);
        expAddr.push_back(nextStoreAddr);
        expData.push_back(regModel[rt]);
        emitI(`MIPS_OP_SW, 5'd0, rt, nextStoreAddr[15:0]);
        nextStoreAddr += 32'd4;
    endtask

    // Branch over one store that is expected only on fall-through
    task automatic branchOverStore(input logic [5:0] op, input logic [4:0] rs,
                                   input logic [4:0] rt);
        logic taken;
        taken = (op == `MIPS_OP_BEQ) ? (regModel[rs] == regModel[rt])
                                     : (regModel[rs] != regModel[rt]);
        emitI(op, rs, rt, 16'h0001);
        if (taken) begin
            emitI(`MIPS_OP_SW, 5'd0, rs, nextStoreAddr[15:0]);
            nextStoreAddr += 32'd4;
        end else begin
            storeReg(rs);
        end
    endtask

    task automatic buildProgram();
        logic [31:0] r;
        logic [15:0] imm;
        logic [4:0]  sh;
        loadConst(5'd1, takeBits(32));
        loadConst(5'd2, takeBits(32));
        aluR(`MIPS_FN_ADDU, 5'd3, 5'd1, 5'd2, 5'd0);
        storeReg(5'd3);
        aluR(`MIPS_FN_SUBU, 5'd3, 5'd1, 5'd2, 5'd0);
        storeReg(5'd3);
        aluR(`MIPS_FN_AND, 5'd3, 5'd1, 5'd2, 5'd0);
        storeReg(5'd3);
        aluR(`MIPS_FN_OR, 5'd3, 5'd1, 5'd2, 5'd0);
        storeReg(5'd3);
        aluR(`MIPS_FN_XOR, 5'd3, 5'd1, 5'd2, 5'd0);
        storeReg(5'd3);
        // Both operand orders so SLT gives 0 and 1
        aluR(`MIPS_FN_SLT, 5'd3, 5'd1, 5'd2, 5'd0);
        storeReg(5'd3);
        aluR(`MIPS_FN_SLT, 5'd3, 5'd2, 5'd1, 5'd0);
        storeReg(5'd3);
        r  = takeBits(5);
        sh = r[4:0];
        aluR(`MIPS_FN_SLL, 5'd3, 5'd0, 5'd1, sh);
        storeReg(5'd3);
        r  = takeBits(5);
        sh = r[4:0];
        aluR(`MIPS_FN_SRL, 5'd3, 5'd0, 5'd2, sh);
        storeReg(5'd3);
        r   = takeBits(16);
        imm = r[15:0];
        emitI(`MIPS_OP_ADDIU, 5'd1, 5'd3, imm);
        regModel[3] = regModel[1] + {{16{imm[15]}}, imm};
        storeReg(5'd3);
        r   = takeBits(16);
        imm = r[15:0];
        emitI(`MIPS_OP_ORI, 5'd2, 5'd3, imm);
        regModel[3] = regModel[2] | {16'h0000, imm};
        storeReg(5'd3);
        r   = takeBits(16);
        imm = r[15:0];
        emitI(`MIPS_OP_LUI, 5'd0, 5'd3, imm);
        regModel[3] = {imm, 16'h0000};
        storeReg(5'd3);
        // Back-to-back dependent chain
        aluR(`MIPS_FN_ADDU, 5'd4, 5'd1, 5'd2, 5'd0);
        aluR(`MIPS_FN_SUBU, 5'd5, 5'd4, 5'd1, 5'd0);
        aluR(`MIPS_FN_XOR, 5'd6, 5'd5, 5'd4, 5'd0);
        storeReg(5'd5);
        storeReg(5'd6);
        // Reload the first stored word and store it again
        emitI(`MIPS_OP_LW, 5'd0, 5'd8, expAddr[0][15:0]);
        regModel[8] = expData[0];
        storeReg(5'd8);
        branchOverStore(`MIPS_OP_BEQ, 5'd1, 5'd1);
        branchOverStore(`MIPS_OP_BNE, 5'd1, 5'd2);
        branchOverStore(`MIPS_OP_BEQ, 5'd1, 5'd2);
        branchOverStore(`MIPS_OP_BNE, 5'd2, 5'd2);
        storeReg(5'd4);
        emitR(5'd0, 5'd0, 5'd0, 5'd0, `MIPS_FN_SYSCALL);
    endtask

    // --------------------------------------------------
    // Checking
    // --------------------------------------------------
    task automatic checkReset();
        assert (memRead === 1'b0) else begin
            errors++;
            $display("Fail memRead: got %h, expected 0", memRead);
        end
        assert (memWrite === 1'b0) else begin
            errors++;
            $display("Fail memWrite: got %h, expected 0", memWrite);
        end
        assert (sys === 1'b0) else begin
            errors++;
            $display("Fail sys: got %h, expected 0", sys);
        end
        assert (instrAddr === `MIPS_RESET_PC) else begin
            errors++;
            $display("Fail instrAddr: got %h, expected %h", instrAddr, `MIPS_RESET_PC);
        end
    endtask

    always @(negedge CLK) begin
        if (!arstN) begin
            checkReset();
        end
        assert (!(memRead && memWrite)) else begin
            errors++;
            $display("memRead and memWrite are high together at %0t", $time);
        end
        if (sysSeen) begin
            assert (sys) else begin
                errors++;
                $display("sys dropped after it had risen at %0t", $time);
            end
        end
        if (memWrite) begin
            assert (!sys) else begin
                errors++;
                $display("A store was written after sys rose at %0t", $time);
            end
            assert (expAddr.size() != 0) else begin
                errors++;
                $display("Unexpected store to %h at %0t", dataAddr, $time);
            end
            if (expAddr.size() != 0) begin
                assert (dataAddr === expAddr[0]) else begin
                    errors++;
                    $display("Fail dataAddr: got %h, expected %h", dataAddr, expAddr[0]);
                end
                assert (dataWrite === expData[0]) else begin
                    errors++;
                    $display("Fail dataWrite: got %h, expected %h", dataWrite, expData[0]);
                end
                void'(expAddr.pop_front());
                void'(expData.pop_front());
                storesSeen++;
            end
        end
        if (sys && !sysSeen) begin
            sysSeen = 1'b1;
            assert (expAddr.size() == 0) else begin
                errors++;
                $display("sys rose with %0d stores still outstanding", expAddr.size());
            end
        end
    end

    initial begin
        arstN         = 1'b0;
        errors        = 0;
        storesSeen    = 0;
        sysSeen       = 1'b0;
        pcIdx         = 0;
        lfsr          = 32'h221;
        nextStoreAddr = 32'h0000_0100;
        for (int i = 0; i < MemWords; i++) begin
            // Unused opcode that the program never reaches
            imem[i] = {6'h3f, 26'(i)};
            dmem[i] = 32'h5a00_0000 ^ (i * 32'h0001_0203);
        end
        for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
            regModel[i] = 32'h0;
        end
        buildProgram();

        for (int c = 0; c < 4; c++) begin
            @(posedge CLK);
        end
        arstN <= 1'b1;
        @(negedge CLK);
        checkReset();

        for (int i = 0; i < WaitLimit && !sys; i++) begin
            @(negedge CLK);
        end
        if (!sys) begin
            errors++;
            $display("Timed out after %0d cycles waiting for sys", WaitLimit);
        end
        // A few more cycles to see that sys holds and no store follows
        for (int i = 0; i < TailLimit; i++) begin
            @(negedge CLK);
        end
        assert (expAddr.size() == 0) else begin
            errors++;
            $display("%0d expected stores were never written", expAddr.size());
        end

        $display("Errors: %0d, stores checked: %0d", errors, storesSeen);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+rtl
rtl/mipsPkg.sv
rtl/mipsIfs.sv
rtl/mipsFetch.sv
rtl/mipsDecode.sv
rtl/mipsExecute.sv
rtl/mipsResult.sv
rtl/mipsCore.sv
dv/mipsTb.sv

/* rtl/mipsConsts.svh */
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Datapath and register file sizes
`define MIPS_XLEN       32
`define MIPS_NUM_REGS   32
`define MIPS_REG_BITS   5
`define MIPS_IQ_DEPTH   4
`define MIPS_RESET_PC   32'h0000_0000

// Primary opcodes
`define MIPS_OP_RTYPE   6'h00
`define MIPS_OP_ADDIU   6'h09
`define MIPS_OP_ORI     6'h0d
`define MIPS_OP_LUI     6'h0f
`define MIPS_OP_LW      6'h23
`define MIPS_OP_SW      6'h2b
`define MIPS_OP_BEQ     6'h04
`define MIPS_OP_BNE     6'h05

// Funct field of R-type
`define MIPS_FN_ADDU    6'h21
`define MIPS_FN_SUBU    6'h23
`define MIPS_FN_AND     6'h24
`define MIPS_FN_OR      6'h25
`define MIPS_FN_XOR     6'h26
`define MIPS_FN_SLT     6'h2a
`define MIPS_FN_SLL     6'h00
`define MIPS_FN_SRL     6'h02
`define MIPS_FN_SYSCALL 6'h0c

`endif

/* rtl/mipsCore.sv */
`timescale 1ns/1ns
`include "mipsConsts.svh"

module mipsCore (
    input  logic                  CLK,
    input  logic                  arstN,
    output logic [`MIPS_XLEN-1:0] instrAddr,
    input  logic [`MIPS_XLEN-1:0] instrData,
    output logic [`MIPS_XLEN-1:0] dataAddr,
    output logic                  memRead,
    output logic                  memWrite,
    output logic [`MIPS_XLEN-1:0] dataWrite,
    input  logic [`MIPS_XLEN-1:0] dataRead,
    output logic                  sys
);

    // Fetch queue head and redirect
    logic                  qValid;
    logic [`MIPS_XLEN-1:0] qInstr;
    logic [`MIPS_XLEN-1:0] qPc;
    logic                  qPop;
    logic                  redirect;
    logic [`MIPS_XLEN-1:0] redirectPc;

    // Write-back into the register file
    logic                  wbEnable;
    mipsPkg::regIdxT       wbReg;
    logic [`MIPS_XLEN-1:0] wbData;

    issueIf   issueBus ();
    execOutIf exBus ();

    mipsFetch fetchStage (
        .CLK        (CLK),
        .arstN      (arstN),
        .qPop       (qPop),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .instrData  (instrData),
        .instrAddr  (instrAddr),
        .qValid     (qValid),
        .qInstr     (qInstr),
        .qPc        (qPc)
    );

    mipsDecode decodeStage (
        .CLK        (CLK),
        .arstN      (arstN),
        .qValid     (qValid),
        .qInstr     (qInstr),
        .qPc        (qPc),
        .wbEnable   (wbEnable),
        .wbReg      (wbReg),
        .wbData     (wbData),
        .execBusy   (exBus),
        .qPop       (qPop),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .sys        (sys),
        .issue      (issueBus)
    );

    mipsExecute executeStage (
        .CLK   (CLK),
        .arstN (arstN),
        .issue (issueBus),
        .exOut (exBus)
    );

    mipsResult resultStage (
        .CLK       (CLK),
        .arstN     (arstN),
        .dataRead  (dataRead),
        .exOut     (exBus),
        .dataAddr  (dataAddr),
        .dataWrite (dataWrite),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .wbEnable  (wbEnable),
        .wbReg     (wbReg),
        .wbData    (wbData)
    );

endmodule

/* rtl/mipsDecode.sv */
`timescale 1ns/1ns
`include "mipsConsts.svh"

module mipsDecode (
    input  logic                  CLK,
    input  logic                  arstN,
    input  logic                  qValid,
    input  logic [`MIPS_XLEN-1:0] qInstr,
    input  logic [`MIPS_XLEN-1:0] qPc,
    input  logic                  wbEnable,
    input  mipsPkg::regIdxT       wbReg,
    input  logic [`MIPS_XLEN-1:0] wbData,
    execOutIf.result              execBusy,
    output logic                  qPop,
    output logic                  redirect,
    output logic [`MIPS_XLEN-1:0] redirectPc,
    output logic                  sys,
    issueIf.decode                issue
);

    logic [`MIPS_XLEN-1:0] regFile [`MIPS_NUM_REGS];
    logic [5:0]            opcode;
    logic [5:0]            funct;
    mipsPkg::regIdxT       rs;
    mipsPkg::regIdxT       rt;
    logic [`MIPS_XLEN-1:0] immSext;
    logic [`MIPS_XLEN-1:0] immZext;
    logic [`MIPS_XLEN-1:0] rsVal;
    logic [`MIPS_XLEN-1:0] rtVal;
    logic                  usesRs;
    logic                  usesRt;
    logic                  isBranch;
    logic                  isBne;
    logic                  isSyscall;
    logic                  execWrites;
    logic                  rsHit;
    logic                  rtHit;
    logic                  canIssue;
    logic                  branchTaken;
    logic                  halted;
    logic                  resultBusy;

    assign opcode  = qInstr[31:26];
    assign rs      = qInstr[25:21];
    assign rt      = qInstr[20:16];
    assign funct   = qInstr[5:0];
    assign immSext = {{(`MIPS_XLEN-16){qInstr[15]}}, qInstr[15:0]};
    assign immZext = {{(`MIPS_XLEN-16){1'b0}}, qInstr[15:0]};

    // Register file, write at the end of the result cycle
    always_ff @(posedge CLK) begin
        if (wbEnable) begin
            regFile[wbReg] <= wbData;
        end
    end

    // Reads see this cycle's write-back; r0 reads as zero
    assign rsVal = (rs == '0) ? '0 : (wbEnable && wbReg == rs) ? wbData : regFile[rs];
    assign rtVal = (rt == '0) ? '0 : (wbEnable && wbReg == rt) ? wbData : regFile[rt];

    // --------------------------------------------------
    // Opcode and funct decode
    // --------------------------------------------------
    always_comb begin
        issue.aluOp     = mipsPkg::aluAdd;
        issue.operandA  = rsVal;
        issue.operandB  = rtVal;
        issue.shamt     = qInstr[10:6];
        issue.storeData = rtVal;
        issue.destReg   = qInstr[15:11];
        issue.regWrite  = 1'b0;
        issue.memRead   = 1'b0;
        issue.memWrite  = 1'b0;
        usesRs          = 1'b0;
        usesRt          = 1'b0;
        isBranch        = 1'b0;
        isBne           = 1'b0;
        isSyscall       = 1'b0;
        case (opcode)
            `MIPS_OP_RTYPE: begin
                usesRs         = 1'b1;
                usesRt         = 1'b1;
                issue.regWrite = 1'b1;
                case (funct)
                    `MIPS_FN_ADDU: issue.aluOp = mipsPkg::aluAdd;
                    `MIPS_FN_SUBU: issue.aluOp = mipsPkg::aluSub;
                    `MIPS_FN_AND:  issue.aluOp = mipsPkg::aluAnd;
                    `MIPS_FN_OR:   issue.aluOp = mipsPkg::aluOr;
                    `MIPS_FN_XOR:  issue.aluOp = mipsPkg::aluXor;
                    `MIPS_FN_SLT:  issue.aluOp = mipsPkg::aluSlt;
                    `MIPS_FN_SLL, `MIPS_FN_SRL: begin
                        // Shifts act on rt
                        issue.aluOp    = (funct == `MIPS_FN_SLL) ? mipsPkg::aluSll
                                                                 : mipsPkg::aluSrl;
                        issue.operandA = rtVal;
                        usesRs         = 1'b0;
                    end
                    `MIPS_FN_SYSCALL: begin
                        isSyscall      = 1'b1;
                        issue.regWrite = 1'b0;
                        usesRs         = 1'b0;
                        usesRt         = 1'b0;
                    end
                    default: issue.regWrite = 1'b0;
                endcase
            end
            `MIPS_OP_ADDIU, `MIPS_OP_ORI, `MIPS_OP_LUI, `MIPS_OP_LW: begin
                usesRs         = (opcode != `MIPS_OP_LUI);
                issue.destReg  = rt;
                issue.regWrite = 1'b1;
                issue.memRead  = (opcode == `MIPS_OP_LW);
                issue.operandB = immSext;
                if (opcode == `MIPS_OP_ORI) begin
                    issue.aluOp    = mipsPkg::aluOr;
                    issue.operandB = immZext;
                end else if (opcode == `MIPS_OP_LUI) begin
                    issue.aluOp    = mipsPkg::aluLui;
                    issue.operandB = immZext;
                end
            end
            `MIPS_OP_SW: begin
                usesRs         = 1'b1;
                usesRt         = 1'b1;
                issue.operandB = immSext;
                issue.memWrite = 1'b1;
            end
            `MIPS_OP_BEQ, `MIPS_OP_BNE: begin
                usesRs   = 1'b1;
                usesRt   = 1'b1;
                isBranch = 1'b1;
                isBne    = (opcode == `MIPS_OP_BNE);
            end
            default: ;
        endcase
    end

    // --------------------------------------------------
    // Hazard stall, issue and branch redirect
    // --------------------------------------------------
    assign execWrites = execBusy.valid && execBusy.regWrite;
    assign rsHit = usesRs && (rs != '0) &&
                   ((execWrites && execBusy.destReg == rs) || (wbEnable && wbReg == rs));
    assign rtHit = usesRt && (rt != '0) &&
                   ((execWrites && execBusy.destReg == rt) || (wbEnable && wbReg == rt));

    assign canIssue    = qValid && !halted && !rsHit && !rtHit;
    assign qPop        = canIssue;
    // Branches and SYSCALL leave a bubble behind
    assign issue.valid = canIssue && !isBranch && !isSyscall;

    assign branchTaken = isBne ? (rsVal != rtVal) : (rsVal == rtVal);
    assign redirect    = canIssue && isBranch && branchTaken;
    assign redirectPc  = qPc + `MIPS_XLEN'd4 + {immSext[`MIPS_XLEN-3:0], 2'b00};

    // Halt once SYSCALL is popped, sys when the pipe has drained
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            halted     <= 1'b0;
            resultBusy <= 1'b0;
            sys        <= 1'b0;
        end else begin
            resultBusy <= execBusy.valid;
            if (canIssue && isSyscall) begin
                halted <= 1'b1;
            end
            if (halted && !execBusy.valid && !resultBusy) begin
                sys <= 1'b1;
            end
        end
    end

endmodule

/* rtl/mipsExecute.sv */
`timescale 1ns/1ns
`include "mipsConsts.svh"

module mipsExecute (
    input logic       CLK,
    input logic       arstN,
    issueIf.execute   issue,
    execOutIf.execute exOut
);

    mipsPkg::aluOpT        aluOpQ;
    logic [`MIPS_XLEN-1:0] opAQ;
    logic [`MIPS_XLEN-1:0] opBQ;
    logic [`MIPS_XLEN-1:0] storeDataQ;
    logic [4:0]            shamtQ;
    mipsPkg::regIdxT       destRegQ;
    logic                  validQ;
    logic                  regWriteQ;
    logic                  memReadQ;
    logic                  memWriteQ;

    // Stage register, control bits qualified by valid
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            validQ    <= 1'b0;
            regWriteQ <= 1'b0;
            memReadQ  <= 1'b0;
            memWriteQ <= 1'b0;
        end else begin
            validQ    <= issue.valid;
            regWriteQ <= issue.valid && issue.regWrite;
            memReadQ  <= issue.valid && issue.memRead;
            memWriteQ <= issue.valid && issue.memWrite;
        end
    end

    always_ff @(posedge CLK) begin
        aluOpQ     <= issue.aluOp;
        opAQ       <= issue.operandA;
        opBQ       <= issue.operandB;
        shamtQ     <= issue.shamt;
        storeDataQ <= issue.storeData;
        destRegQ   <= issue.destReg;
    end

    // ALU
    always_comb begin
        case (aluOpQ)
            mipsPkg::aluSub: exOut.aluResult = opAQ - opBQ;
            mipsPkg::aluAnd: exOut.aluResult = opAQ & opBQ;
            mipsPkg::aluOr:  exOut.aluResult = opAQ | opBQ;
            mipsPkg::aluXor: exOut.aluResult = opAQ ^ opBQ;
            mipsPkg::aluSlt: begin
                exOut.aluResult = {{(`MIPS_XLEN-1){1'b0}}, $signed(opAQ) < $signed(opBQ)};
            end
            mipsPkg::aluSll: exOut.aluResult = opAQ << shamtQ;
            mipsPkg::aluSrl: exOut.aluResult = opAQ >> shamtQ;
            mipsPkg::aluLui: exOut.aluResult = opBQ << 16;
            default:         exOut.aluResult = opAQ + opBQ;
        endcase
    end

    assign exOut.valid     = validQ;
    assign exOut.storeData = storeDataQ;
    assign exOut.destReg   = destRegQ;
    assign exOut.regWrite  = regWriteQ;
    assign exOut.memRead   = memReadQ;
    assign exOut.memWrite  = memWriteQ;

endmodule

/* rtl/mipsFetch.sv */
`timescale 1ns/1ns
`include "mipsConsts.svh"

module mipsFetch (
    input  logic                  CLK,
    input  logic                  arstN,
    input  logic                  qPop,
    input  logic                  redirect,
    input  logic [`MIPS_XLEN-1:0] redirectPc,
    input  logic [`MIPS_XLEN-1:0] instrData,
    output logic [`MIPS_XLEN-1:0] instrAddr,
    output logic                  qValid,
    output logic [`MIPS_XLEN-1:0] qInstr,
    output logic [`MIPS_XLEN-1:0] qPc
);

    localparam int PtrBits = $clog2(`MIPS_IQ_DEPTH);

    logic [`MIPS_XLEN-1:0] instrSlot [`MIPS_IQ_DEPTH];
    logic [`MIPS_XLEN-1:0] pcSlot [`MIPS_IQ_DEPTH];
    logic [PtrBits-1:0]    head;
    logic [PtrBits-1:0]    tail;
    logic [PtrBits:0]      count;
    logic [`MIPS_XLEN-1:0] pc;
    logic                  push;

    // No push on a redirect, the fetched word is from the wrong path
    assign push = (count != (PtrBits+1)'(`MIPS_IQ_DEPTH)) && !redirect;

    assign instrAddr = pc;
    assign qValid    = (count != '0);
    assign qInstr    = instrSlot[head];
    assign qPc       = pcSlot[head];

    // --------------------------------------------------
    // PC and queue pointers
    // --------------------------------------------------
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            pc    <= `MIPS_RESET_PC;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (redirect) begin
            pc    <= redirectPc;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                pc   <= pc + `MIPS_XLEN'd4;
                tail <= tail + 1'b1;
            end
            if (qPop) begin
                head <= head + 1'b1;
            end
            case ({push, qPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Queue storage
    always_ff @(posedge CLK) begin
        if (push) begin
            instrSlot[tail] <= instrData;
            pcSlot[tail]    <= pc;
        end
    end

endmodule

/* rtl/mipsIfs.sv */
`timescale 1ns/1ns
`include "mipsConsts.svh"

// --------------------------------------------------
// Decode to execute
// --------------------------------------------------
interface issueIf;
    logic                  valid;
    mipsPkg::aluOpT        aluOp;
    logic [`MIPS_XLEN-1:0] operandA;
    // Register value or extended immediate
    logic [`MIPS_XLEN-1:0] operandB;
    logic [4:0]            shamt;
    logic [`MIPS_XLEN-1:0] storeData;
    mipsPkg::regIdxT       destReg;
    logic                  regWrite;
    logic                  memRead;
    logic                  memWrite;

    modport decode (
        output valid, aluOp, operandA, operandB, shamt,
        output storeData, destReg, regWrite, memRead, memWrite
    );

    modport execute (
        input valid, aluOp, operandA, operandB, shamt,
        input storeData, destReg, regWrite, memRead, memWrite
    );
endinterface

// --------------------------------------------------
// Execute to result
// --------------------------------------------------
interface execOutIf;
    logic                  valid;
    // Also the address of a load or store
    logic [`MIPS_XLEN-1:0] aluResult;
    logic [`MIPS_XLEN-1:0] storeData;
    mipsPkg::regIdxT       destReg;
    logic                  regWrite;
    logic                  memRead;
    logic                  memWrite;

    modport execute (
        output valid, aluResult, storeData, destReg, regWrite, memRead, memWrite
    );

    modport result (
        input valid, aluResult, storeData, destReg, regWrite, memRead, memWrite
    );
endinterface

/* rtl/mipsPkg.sv */
`include "mipsConsts.svh"

package mipsPkg;

    // ALU function selected in decode, carried to execute
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluSrl,
        aluLui
    } aluOpT;

    // Architectural register index
    typedef logic [`MIPS_REG_BITS-1:0] regIdxT;

endpackage

/* rtl/mipsResult.sv */
`timescale 1ns/1ns
`include "mipsConsts.svh"

module mipsResult (
    input  logic                  CLK,
    input  logic                  arstN,
    input  logic [`MIPS_XLEN-1:0] dataRead,
    execOutIf.result              exOut,
    output logic [`MIPS_XLEN-1:0] dataAddr,
    output logic [`MIPS_XLEN-1:0] dataWrite,
    output logic                  memRead,
    output logic                  memWrite,
    output logic                  wbEnable,
    output mipsPkg::regIdxT       wbReg,
    output logic [`MIPS_XLEN-1:0] wbData
);

    logic [`MIPS_XLEN-1:0] resultQ;
    logic [`MIPS_XLEN-1:0] storeDataQ;
    mipsPkg::regIdxT       destRegQ;
    logic                  regWriteQ;

    // Strobes last exactly one cycle; writes to r0 dropped here
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            regWriteQ <= 1'b0;
            memRead   <= 1'b0;
            memWrite  <= 1'b0;
        end else begin
            regWriteQ <= exOut.valid && exOut.regWrite && (exOut.destReg != '0);
            memRead   <= exOut.valid && exOut.memRead;
            memWrite  <= exOut.valid && exOut.memWrite;
        end
    end

    always_ff @(posedge CLK) begin
        resultQ    <= exOut.aluResult;
        storeDataQ <= exOut.storeData;
        destRegQ   <= exOut.destReg;
    end

    assign dataAddr  = resultQ;
    assign dataWrite = storeDataQ;

    // Load data or ALU result back to decode
    assign wbEnable = regWriteQ;
    assign wbReg    = destRegQ;
    assign wbData   = memRead ? dataRead : resultQ;

endmodule

/* runSim.sh */
#!/bin/sh
# Compile and run the mipsCore testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f filelist.f --top-module mipsTb -o mipsTbSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mipsTbSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
exit 1
